//--- vlog.f
hw/memGamePkg.sv
hw/cursorControl.sv
hw/memoryBoard.sv
hw/matchTracker.sv
hw/gameTimer.sv
hw/boardBusSlave.sv
hw/memoryGameTop.sv
tb/clockGen.sv
tb/memoryGameTb.sv

//--- Makefile
# Verilator build and run of the memory game testbench
TOP = memoryGameTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb/memoryGameTb.sv
module memoryGameTb;
	import memGamePkg::*;

	logic clk;
	logic genRstN;
	logic extraRstN;
	logic rstN;
	logic btnUp;
	logic btnDown;
	logic btnLeft;
	logic btnRight;
	logic btnSelect;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [busAdrW-1:0] wbAdr;
	logic [busDatW-1:0] wbDatI;
	logic [busDatW-1:0] wbDatO;
	logic wbAck;
	logic [cardW-1:0] lastCard;
	logic gameWon;
	logic timeUp;

	// Expected board, cursor, pick phase and counters of the game
	logic [15:0] expUp;
	logic [1:0] curRow;
	logic [1:0] curCol;
	logic expPhase;
	int firstIdx;
	logic [3:0] expPairs;
	logic expTimeUp;
	logic [3:0] expLast;

	int checks;
	int errors;
	int seed;
	int order[6] = '{1, 2, 4, 5, 6, 7};

	// The second reset in the time-limit test is ANDed onto the power-on reset
	assign rstN = genRstN && extraRstN;

	clockGen clkGen_i (.clk(clk), .rstN(genRstN));

	memoryGameTop dut_i (
		.clk(clk), .rstN(rstN),
		.btnUp(btnUp), .btnDown(btnDown), .btnLeft(btnLeft), .btnRight(btnRight),
		.btnSelect(btnSelect),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatI(wbDatI),
		.wbDatO(wbDatO), .wbAck(wbAck),
		.lastCard(lastCard), .gameWon(gameWon), .timeUp(timeUp)
	);

	// Symbol of a cell in the fixed layout where cell 0 is the lowest nibble
	function automatic logic [2:0] layoutSymbol(input int idx);
		return initialLayout[4*idx +: 3];
	endfunction

	task automatic checkEqual(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
		end
	endtask

	// Raises one button for a single cycle starting 2 units after a rising edge
	task automatic pulseButton(input string name);
		@(posedge clk);
		#2;
		btnUp = (name == "up");
		btnDown = (name == "down");
		btnLeft = (name == "left");
		btnRight = (name == "right");
		btnSelect = (name == "select");
		@(posedge clk);
		#2;
		btnUp = 1'b0;
		btnDown = 1'b0;
		btnLeft = 1'b0;
		btnRight = 1'b0;
		btnSelect = 1'b0;
	endtask

	// Reaches any cell with right and down only because both wrap after the last column or row
	task automatic moveCursor(input logic [1:0] row, input logic [1:0] col);
		while (curCol != col) begin
			pulseButton("right");
			curCol = curCol + 2'd1;
		end
		while (curRow != row) begin
			pulseButton("down");
			curRow = curRow + 2'd1;
		end
	endtask

	// Selects a cell and updates the expected board by the pick rules
	task automatic pickCard(input int idx);
		logic [2:0] sym;
		sym = layoutSymbol(idx);
		moveCursor(2'(idx / 4), 2'(idx % 4));
		pulseButton("select");
		// Face-up cards and a finished game make the select a no-op
		if (!expUp[idx] && !expTimeUp && expPairs != 4'd8) begin
			if (!expPhase) begin
				expUp[idx] = 1'b1;
				firstIdx = idx;
				expLast = {1'b1, sym};
			end else if (sym == layoutSymbol(firstIdx)) begin
				expUp[idx] = 1'b1;
				expPairs = expPairs + 4'd1;
				expLast = {1'b1, sym};
			end else begin
				// A mismatch hides the first card again and the second never stays up
				expUp[firstIdx] = 1'b0;
				expLast = {1'b0, sym};
			end
			expPhase = !expPhase;
		end
		checkEqual("lastCard", {4'd0, lastCard}, {4'd0, expLast});
	endtask

	// Wishbone classic read that holds the strobe until the acknowledge has been seen
	task automatic busRead(input logic [4:0] adr, output logic [7:0] data);
		int waitCount;
		logic ackSeen;
		@(posedge clk);
		#2;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbAdr = adr;
		waitCount = 0;
		ackSeen = 1'b0;
		while (!ackSeen && waitCount < 20) begin
			@(posedge clk);
			#1;
			ackSeen = wbAck;
			waitCount++;
		end
		if (!ackSeen) begin
			errors++;
			$display("Timeout: the bus never acknowledged a read of address %0d", adr);
		end
		data = wbDatO;
		// The strobe is still up across this edge, so the acknowledge must drop by itself
		@(posedge clk);
		#1;
		checkEqual("wbAck after acknowledge", {7'd0, wbAck}, 8'd0);
		#1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	task automatic checkCell(input int idx);
		logic [7:0] data;
		busRead(5'(idx), data);
		checkEqual($sformatf("cell %0d", idx), data, {4'd0, expUp[idx], layoutSymbol(idx)});
	endtask

	task automatic checkBoard();
		for (int i = 0; i < 16; i++)
			checkCell(i);
	endtask

	// Status byte is timeUp, gameWon and the pair count from bit 5 down
	task automatic checkStatus();
		logic [7:0] data;
		busRead(statusAdr, data);
		checkEqual("status", data, {2'd0, expTimeUp, expPairs == 4'd8, expPairs});
	endtask

	task automatic resetModel();
		expUp = '0;
		curRow = 2'd0;
		curCol = 2'd0;
		expPhase = 1'b0;
		firstIdx = 0;
		expPairs = 4'd0;
		expTimeUp = 1'b0;
		expLast = 4'd0;
	endtask

	initial begin
		logic [7:0] data;
		logic [7:0] firstSeconds;
		logic [31:0] r;
		int waitCount;
		int j;
		int tmp;
		int a;
		int b;
		btnUp = 1'b0;
		btnDown = 1'b0;
		btnLeft = 1'b0;
		btnRight = 1'b0;
		btnSelect = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatI = '0;
		extraRstN = 1'b1;
		checks = 0;
		errors = 0;
		seed = 32'h7a45783f;
		resetModel();

		waitCount = 0;
		while (!rstN && waitCount < 20) begin
			@(posedge clk);
			#1;
			waitCount++;
		end
		if (!rstN) begin
			errors++;
			$display("Timeout: reset was never released");
		end

		// After reset every card is face down and all registers are clear
		checkEqual("wbAck after reset", {7'd0, wbAck}, 8'd0);
		checkBoard();
		checkStatus();
		busRead(cursorAdr, data);
		checkEqual("cursor after reset", data, 8'd0);

		// Left and up both wrap from 0 to 3
		pulseButton("left");
		pulseButton("up");
		curRow = 2'd3;
		curCol = 2'd3;
		busRead(cursorAdr, data);
		checkEqual("cursor after wrap", data, 8'h0f);

		// Symbol 0 sits at (0,0) and at (2,3)
		pickCard(0);
		pickCard(11);
		checkCell(0);
		checkCell(11);
		checkStatus();

		// Symbols 3 and 6 do not match, so both cards go back down
		pickCard(1);
		pickCard(2);
		checkCell(1);
		checkCell(2);
		checkStatus();
		// A face-up card is ignored and the pair after it must still be judged as a pair
		pickCard(0);
		pickCard(1);
		pickCard(15);
		checkCell(1);
		checkCell(15);
		checkStatus();

		// Remaining six symbols in a shuffled order
		for (int i = 5; i > 0; i--) begin
			r = $random(seed);
			j = int'(r[15:0]) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int k = 0; k < 6; k++) begin
			a = -1;
			b = -1;
			for (int i = 0; i < 16; i++) begin
				if (layoutSymbol(i) == 3'(order[k])) begin
					if (a < 0)
						a = i;
					else
						b = i;
				end
			end
			pickCard(a);
			pickCard(b);
			checkCell(a);
			checkCell(b);
			checkStatus();
		end
		checkEqual("gameWon", {7'd0, gameWon}, 8'd1);
		// The timer is frozen by the win
		busRead(secondsAdr, firstSeconds);
		repeat (3 * ticksPerSecond) @(posedge clk);
		busRead(secondsAdr, data);
		checkEqual("seconds after win", data, firstSeconds);

		// New game that nobody plays until the time runs out
		@(posedge clk);
		#2 extraRstN = 1'b0;
		repeat (5) @(posedge clk);
		#2 extraRstN = 1'b1;
		resetModel();
		waitCount = 0;
		while (!timeUp && waitCount < timeLimit * ticksPerSecond + 50) begin
			@(posedge clk);
			#1;
			waitCount++;
		end
		if (!timeUp) begin
			errors++;
			$display("Timeout: the time limit passed without timeUp rising");
		end
		expTimeUp = 1'b1;
		busRead(secondsAdr, data);
		checkEqual("seconds at time up", data, 8'(timeLimit));
		checkStatus();
		// Selects after the time limit leave the board alone
		pickCard(5);
		checkBoard();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- tb/clockGen.sv
module clockGen (
	output logic clk,
	output logic rstN
);

	// Free-running clock with a period of 20 time units
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Power-on reset held low for five rising edges
	// Released a little after the edge, like every other driven input
	initial begin
		rstN = 1'b0;
		repeat (5) @(posedge clk);
		#2 rstN = 1'b1;
	end

endmodule

//--- hw/memoryGameTop.sv
module memoryGameTop (
	input logic clk,
	input logic rstN,
	input logic btnUp,
	input logic btnDown,
	input logic btnLeft,
	input logic btnRight,
	input logic btnSelect,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [memGamePkg::busAdrW-1:0] wbAdr,
	input logic [memGamePkg::busDatW-1:0] wbDatI,
	output logic [memGamePkg::busDatW-1:0] wbDatO,
	output logic wbAck,
	output logic [memGamePkg::cardW-1:0] lastCard,
	output logic gameWon,
	output logic timeUp
);
	import memGamePkg::*;

	// Cursor position shared by the board and the bus
	logic [posW-1:0] posX;
	logic [posW-1:0] posY;

	// Pick handshake between the board and the match tracker
	logic pickFirst;
	logic pickSecond;
	logic [symbolW-1:0] pickSymbol;
	logic pairMatch;

	logic [pairCountW-1:0] pairsFound;
	logic [secondsW-1:0] seconds;
	logic [63:0] boardFlat;
	logic gameOver;

	// Selects are ignored once the game is won or the time has run out
	assign gameOver = gameWon || timeUp;

	cursorControl cursor_i (
		.clk(clk), .rstN(rstN),
		.btnUp(btnUp), .btnDown(btnDown), .btnLeft(btnLeft), .btnRight(btnRight),
		.posX(posX), .posY(posY)
	);

	memoryBoard board_i (
		.clk(clk), .rstN(rstN), .btnSelect(btnSelect), .gameOver(gameOver),
		.posX(posX), .posY(posY), .pairMatch(pairMatch),
		.pickFirst(pickFirst), .pickSecond(pickSecond), .pickSymbol(pickSymbol),
		.lastCard(lastCard), .boardFlat(boardFlat)
	);

	matchTracker tracker_i (
		.clk(clk), .rstN(rstN),
		.pickFirst(pickFirst), .pickSecond(pickSecond), .pickSymbol(pickSymbol),
		.pairMatch(pairMatch), .pairsFound(pairsFound), .gameWon(gameWon)
	);

	gameTimer timer_i (
		.clk(clk), .rstN(rstN), .gameWon(gameWon),
		.seconds(seconds), .timeUp(timeUp)
	);

	boardBusSlave bus_i (
		.clk(clk), .rstN(rstN),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatI(wbDatI),
		.wbDatO(wbDatO), .wbAck(wbAck),
		.boardFlat(boardFlat), .posX(posX), .posY(posY), .pairsFound(pairsFound),
		.gameWon(gameWon), .seconds(seconds), .timeUp(timeUp)
	);

endmodule

//--- hw/boardBusSlave.sv
module boardBusSlave (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [memGamePkg::busAdrW-1:0] wbAdr,
	input logic [memGamePkg::busDatW-1:0] wbDatI,
	output logic [memGamePkg::busDatW-1:0] wbDatO,
	output logic wbAck,
	input logic [63:0] boardFlat,
	input logic [memGamePkg::posW-1:0] posX,
	input logic [memGamePkg::posW-1:0] posY,
	input logic [memGamePkg::pairCountW-1:0] pairsFound,
	input logic gameWon,
	input logic [memGamePkg::secondsW-1:0] seconds,
	input logic timeUp
);
	import memGamePkg::*;

	logic busReq;
	logic [cardW-1:0] cellData;
	logic [busDatW-1:0] readData;

	// A new request is seen only while no acknowledge is out
	// This forces one idle cycle between acknowledges
	assign busReq = wbCyc && wbStb && !wbAck;

	// Low address bits pick one of the sixteen cells
	assign cellData = boardFlat[cardW*wbAdr[2*posW-1:0] +: cardW];

	// Address decode, unmapped addresses read as zero
	always_comb begin
		readData = '0;
		if (wbAdr < busAdrW'(boardDim*boardDim)) begin
			readData = busDatW'(cellData);
		end else begin
			case (wbAdr)
				statusAdr: readData = busDatW'({timeUp, gameWon, pairsFound});
				secondsAdr: readData = busDatW'(seconds);
				cursorAdr: readData = busDatW'({posY, posX});
				default: readData = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			wbAck <= 1'b0;
		else
			wbAck <= busReq;
	end

	// Read data is registered with the request and valid during wbAck
	// Every register here is read-only, so wbDatI is dropped and a write returns zero
	always_ff @(posedge clk) begin
		if (busReq)
			wbDatO <= wbWe ? '0 : readData;
	end

endmodule

//--- hw/gameTimer.sv
module gameTimer (
	input logic clk,
	input logic rstN,
	input logic gameWon,
	output logic [memGamePkg::secondsW-1:0] seconds,
	output logic timeUp
);
	import memGamePkg::*;

	// Prescaler counts clocks within the current second
	logic [tickW-1:0] tickCount;
	logic secondTick;
	logic running;

	assign secondTick = (tickCount == tickW'(ticksPerSecond - 1));

	// Both counters hold once the game is decided either way
	assign running = !timeUp && !gameWon;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			tickCount <= '0;
			seconds <= '0;
		end else if (running) begin
			if (secondTick) begin
				tickCount <= '0;
				seconds <= seconds + 1'b1;
			end else begin
				tickCount <= tickCount + 1'b1;
			end
		end
	end

	// Time is up at the edge where the limit is reached
	// The counter then stops, so the flag stays high until reset
	assign timeUp = (seconds == secondsW'(timeLimit));

endmodule

//--- hw/matchTracker.sv
module matchTracker (
	input logic clk,
	input logic rstN,
	input logic pickFirst,
	input logic pickSecond,
	input logic [memGamePkg::symbolW-1:0] pickSymbol,
	output logic pairMatch,
	output logic [memGamePkg::pairCountW-1:0] pairsFound,
	output logic gameWon
);
	import memGamePkg::*;

	// Symbol of the first card of the current pair
	logic [symbolW-1:0] firstSymbol;

	always_ff @(posedge clk) begin
		if (pickFirst)
			firstSymbol <= pickSymbol;
	end

	// Answered in the same cycle as the second pick
	// memoryBoard uses it to keep both cards up or hide both
	assign pairMatch = pickSecond && (pickSymbol == firstSymbol);

	// One more pair on every matching second pick
	always_ff @(posedge clk) begin
		if (!rstN)
			pairsFound <= '0;
		else if (pairMatch)
			pairsFound <= pairsFound + 1'b1;
	end

	// The win follows the count directly, so it rises at the edge of the last match
	assign gameWon = (pairsFound == pairCountW'(numPairs));

endmodule

//--- hw/memoryBoard.sv
module memoryBoard (
	input logic clk,
	input logic rstN,
	input logic btnSelect,
	input logic gameOver,
	input logic [memGamePkg::posW-1:0] posX,
	input logic [memGamePkg::posW-1:0] posY,
	input logic pairMatch,
	output logic pickFirst,
	output logic pickSecond,
	output logic [memGamePkg::symbolW-1:0] pickSymbol,
	output logic [memGamePkg::cardW-1:0] lastCard,
	output logic [63:0] boardFlat
);
	import memGamePkg::*;

	// The sixteen cards, packed so the whole board loads from the layout constant
	logic [boardDim*boardDim-1:0][cardW-1:0] cells;

	// Cell index of the cursor and of the first pick, row in the upper bits
	logic [2*posW-1:0] cellIdx;
	logic [2*posW-1:0] firstIdx;

	// Low while waiting for the first card of a pair, high while waiting for the second
	logic pickPhase;

	logic validPick;
	logic newFaceUp;

	assign cellIdx = {posY, posX};

	// A pick counts only on a face-down card while the game is still running
	// The first card of a pair is already face up, so it can never be picked twice
	assign validPick = btnSelect && !gameOver && !cells[cellIdx][faceUpBit];

	assign pickFirst = validPick && !pickPhase;
	assign pickSecond = validPick && pickPhase;

	// matchTracker compares this symbol against its stored first symbol
	assign pickSymbol = cells[cellIdx][symbolW-1:0];

	// The picked card stays up on a first pick or a match
	// On a mismatch it ends face down in the same update as its partner
	assign newFaceUp = pickFirst || pairMatch;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cells <= initialLayout;
			pickPhase <= 1'b0;
			lastCard <= '0;
		end else if (validPick) begin
			pickPhase <= !pickPhase;
			cells[cellIdx][faceUpBit] <= newFaceUp;
			lastCard <= {newFaceUp, pickSymbol};
			// Turn the first card back over when the pair does not match
			if (pickSecond && !pairMatch)
				cells[firstIdx][faceUpBit] <= 1'b0;
		end
	end

	// Remember where the first card was so a mismatch can hide it again
	always_ff @(posedge clk) begin
		if (pickFirst)
			firstIdx <= cellIdx;
	end

	// The flat view goes to the bus slave, cell 0 in the lowest nibble
	assign boardFlat = cells;

endmodule

//--- hw/cursorControl.sv
module cursorControl (
	input logic clk,
	input logic rstN,
	input logic btnUp,
	input logic btnDown,
	input logic btnLeft,
	input logic btnRight,
	output logic [memGamePkg::posW-1:0] posX,
	output logic [memGamePkg::posW-1:0] posY
);
	import memGamePkg::*;

	// Row counter
	// Up moves towards row 0 and wraps to the bottom row
	always_ff @(posedge clk) begin
		if (!rstN) begin
			posY <= '0;
		end else if (btnUp) begin
			if (posY == '0)
				posY <= posW'(boardDim - 1);
			else
				posY <= posY - 1'b1;
		end else if (btnDown) begin
			if (posY == posW'(boardDim - 1))
				posY <= '0;
			else
				posY <= posY + 1'b1;
		end
	end

	// Column counter, same scheme as the rows
	// Left moves towards column 0 and wraps to the last column
	always_ff @(posedge clk) begin
		if (!rstN) begin
			posX <= '0;
		end else if (btnLeft) begin
			if (posX == '0)
				posX <= posW'(boardDim - 1);
			else
				posX <= posX - 1'b1;
		end else if (btnRight) begin
			if (posX == posW'(boardDim - 1))
				posX <= '0;
			else
				posX <= posX + 1'b1;
		end
	end

endmodule

//--- hw/memGamePkg.sv
package memGamePkg;

	// The board is square, and a row or column index fits in posW bits
	localparam int boardDim = 4;
	localparam int posW = 2;

	// A card is a face-up flag above a three-bit symbol
	localparam int cardW = 4;
	localparam int faceUpBit = 3;
	localparam int symbolW = 3;

	// Eight symbols, each on two cards
	localparam int numPairs = 8;
	localparam int pairCountW = 4;

	// Cell i sits in bits [4*i +: 4] with i = row*4 + column, so cell 0 is the lowest nibble
	// Rows from the top are 0 3 6 2 / 6 4 1 7 / 1 5 7 0 / 4 2 5 3, every card face down
	localparam logic [63:0] initialLayout = 64'h3524_0751_7146_2630;

	// One second is only ten clocks, which keeps simulation short
	localparam int ticksPerSecond = 10;
	localparam int tickW = $clog2(ticksPerSecond);
	localparam int secondsW = 7;
	localparam int timeLimit = 60;

	// Wishbone address map
	// Addresses 0 to 15 are the cells, followed by the game registers
	localparam int busAdrW = 5;
	localparam int busDatW = 8;
	localparam logic [busAdrW-1:0] statusAdr = 5'd16;
	localparam logic [busAdrW-1:0] secondsAdr = 5'd17;
	localparam logic [busAdrW-1:0] cursorAdr = 5'd18;

endpackage
